//--- src/fetch_types_pkg.sv
//******************************
// byte addresses are 64 bits, a fetch block is 16 bytes with two branch slots
// history is 16 bits wide, newest outcome in bit 0
//******************************
package fetch_types_pkg;

  localparam int unsigned BLOCK_BYTES       = 16;
  localparam int unsigned BLOCK_OFFSET_BITS = $clog2(BLOCK_BYTES);

  typedef logic [63:0] addr_t;

  // global history, shifted left as blocks are fetched
  typedef logic [15:0] ghist_t;

  // bit s set means branch slot s of the block
  typedef logic [1:0] slot_bits_t;

  // fetch output of the front end
  typedef struct packed {
    addr_t      ip;
    ghist_t     ghist;
    slot_bits_t taken;   // slots predicted taken at ip
  } fetch_state_t;

endpackage

//--- src/retire_pkg.sv
//******************************
// one retiring branch per cycle at most
// src_ip is the block address of the branch, not the branch itself
//******************************
package retire_pkg;

  import fetch_types_pkg::*;

  // retire update from the back end
  typedef struct packed {
    logic   valid;        // one cycle strobe
    logic   slot;         // branch slot inside the block
    logic   mispredict;
    addr_t  src_ip;
    addr_t  target_ip;
    ghist_t ghist;        // history seen when the block was fetched
  } retire_t;

endpackage

//--- src/fetch_pc_gen.sv
`timescale 1ns/1ns
//******************************
// advances every cycle, there is no stall input
// targets from the buffer must already be block aligned
// tag_fault is sticky, only rst clears it
//******************************
module fetch_pc_gen
  import fetch_types_pkg::*;
  import retire_pkg::*;
#(
  parameter int TB_INDEX_BITS = 9
) (
  input  logic       clk,
  input  logic       rst,
  input  addr_t      reset_ip,
  input  retire_t    retire,
  input  slot_bits_t taken,
  input  addr_t      target0,
  input  addr_t      target1,
  input  slot_bits_t tag_hit,
  output addr_t      ip,
  output ghist_t     ghist,
  output logic       tag_fault
);

  localparam int GHIST_BITS = $bits(ghist_t);

  // the buffer tag has to keep at least one address bit
  if (TB_INDEX_BITS < 1 || TB_INDEX_BITS > $bits(addr_t) - BLOCK_OFFSET_BITS - 1) begin : g_bad_idx
    $error("fetch_pc_gen: TB_INDEX_BITS out of range");
  end

  addr_t  ip_next;
  ghist_t ghist_next;
  logic   fault_next;
  logic   restore;

  assign restore = retire.valid && retire.mispredict;

  // next block and history, slot 0 wins over slot 1
  always_comb begin
    ip_next    = ip + addr_t'(BLOCK_BYTES);
    ghist_next = {ghist[GHIST_BITS-3:0], 2'b00};   // no taken slot
    fault_next = tag_fault;

    if (taken[0]) begin
      ip_next    = target0;
      ghist_next = {ghist[GHIST_BITS-2:0], 1'b1};
      if (!tag_hit[0]) begin
        fault_next = 1'b1;
      end
    end else if (taken[1]) begin
      ip_next    = target1;
      ghist_next = {ghist[GHIST_BITS-3:0], 2'b01};
      if (!tag_hit[1]) begin
        fault_next = 1'b1;
      end
    end

    // retirement knows better than the speculative shift
    if (restore) begin
      ghist_next = retire.ghist;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ip        <= reset_ip & ~addr_t'(BLOCK_BYTES - 1);   // block aligned
      ghist     <= '0;
      tag_fault <= 1'b0;
    end else begin
      ip        <= ip_next;
      ghist     <= ghist_next;
      tag_fault <= fault_next;
    end
  end

endmodule

//--- src/direction_predictor.sv
`timescale 1ns/1ns
//******************************
// three tables of 2 bit entries, prediction is their XOR
// training flips one table per mispredict in a fixed A, B, C rotation
// PHT_INDEX_BITS must be 4 to 18
//******************************
module direction_predictor
  import fetch_types_pkg::*;
  import retire_pkg::*;
#(
  parameter int PHT_INDEX_BITS = 10
) (
  input  logic       clk,
  input  logic       rst,
  input  addr_t      ip,
  input  ghist_t     ghist,
  input  retire_t    retire,
  output slot_bits_t taken
);

  localparam int NUM_TABLES = 3;
  localparam int ENTRIES    = 2 ** PHT_INDEX_BITS;

  if (PHT_INDEX_BITS < 4 || PHT_INDEX_BITS > 18) begin : g_bad_idx
    $error("direction_predictor: PHT_INDEX_BITS must be 4 to 18");
  end

  typedef logic [PHT_INDEX_BITS-1:0] pht_idx_t;

  slot_bits_t pht [NUM_TABLES][ENTRIES];
  pht_idx_t   rd_idx [NUM_TABLES];
  pht_idx_t   wr_idx [NUM_TABLES];
  logic [1:0] rot;            // table to flip next
  logic       train;
  slot_bits_t flip;

  // history bits used by each table, the rest of the index is block address
  function automatic int unsigned hist_bits(input int unsigned t);
    case (t)
      0:       return 2;
      1:       return PHT_INDEX_BITS - PHT_INDEX_BITS / 2;
      default: return PHT_INDEX_BITS - 2;
    endcase
  endfunction

  // {block address bits, history bits}, truncated to the index width
  function automatic pht_idx_t pht_index(input addr_t a, input ghist_t h,
                                         input int unsigned hbits);
    addr_t blk;
    addr_t hpart;
    blk   = a >> BLOCK_OFFSET_BITS;
    hpart = addr_t'(h) & ((addr_t'(1) << hbits) - addr_t'(1));
    return pht_idx_t'((blk << hbits) | hpart);
  endfunction

  always_comb begin
    for (int t = 0; t < NUM_TABLES; t++) begin
      rd_idx[t] = pht_index(ip, ghist, hist_bits(t));
      wr_idx[t] = pht_index(retire.src_ip, retire.ghist, hist_bits(t));
    end
  end

  assign taken = pht[0][rd_idx[0]] ^ pht[1][rd_idx[1]] ^ pht[2][rd_idx[2]];

  assign train = retire.valid && retire.mispredict;
  assign flip  = slot_bits_t'(1) << retire.slot;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int t = 0; t < NUM_TABLES; t++) begin
        for (int e = 0; e < ENTRIES; e++) begin
          pht[t][e] <= '0;
        end
      end
      rot <= '0;
    end else if (train) begin
      // one flip inverts the XOR for that slot
      pht[rot][wr_idx[rot]] <= pht[rot][wr_idx[rot]] ^ flip;
      rot <= (rot == 2'd2) ? 2'd0 : rot + 2'd1;
    end
  end

endmodule

//--- src/target_buffer.sv
`timescale 1ns/1ns
//******************************
// direct mapped, one bank per slot, indexed above the block offset
// targets are stored block aligned, the low 4 bits read back as zero
//******************************
module target_buffer
  import fetch_types_pkg::*;
  import retire_pkg::*;
#(
  parameter int TB_INDEX_BITS = 9
) (
  input  logic       clk,
  input  logic       rst,
  input  addr_t      ip,
  input  retire_t    retire,
  output addr_t      target0,
  output addr_t      target1,
  output slot_bits_t tag_hit
);

  localparam int ADDR_BITS = $bits(addr_t);
  localparam int ENTRIES   = 2 ** TB_INDEX_BITS;
  localparam int TAG_LSB   = BLOCK_OFFSET_BITS + TB_INDEX_BITS;
  localparam int TAG_BITS  = ADDR_BITS - TAG_LSB;
  localparam int TGT_BITS  = ADDR_BITS - BLOCK_OFFSET_BITS;

  logic [1:0][ENTRIES-1:0] valid_mem;
  logic [TAG_BITS-1:0]     tag_mem [2][ENTRIES];
  logic [TGT_BITS-1:0]     tgt_mem [2][ENTRIES];

  logic [TB_INDEX_BITS-1:0] rd_idx;
  logic [TB_INDEX_BITS-1:0] wr_idx;
  logic [TAG_BITS-1:0]      rd_tag;

  assign rd_idx = ip[BLOCK_OFFSET_BITS +: TB_INDEX_BITS];
  assign rd_tag = ip[ADDR_BITS-1:TAG_LSB];
  assign wr_idx = retire.src_ip[BLOCK_OFFSET_BITS +: TB_INDEX_BITS];

  assign target0 = {tgt_mem[0][rd_idx], {BLOCK_OFFSET_BITS{1'b0}}};
  assign target1 = {tgt_mem[1][rd_idx], {BLOCK_OFFSET_BITS{1'b0}}};

  for (genvar s = 0; s < 2; s++) begin : g_hit
    assign tag_hit[s] = valid_mem[s][rd_idx] && (tag_mem[s][rd_idx] == rd_tag);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_mem <= '0;
    end else if (retire.valid) begin
      valid_mem[retire.slot][wr_idx] <= 1'b1;
    end
  end

  // tag and target of the retiring slot's bank
  always_ff @(posedge clk) begin
    if (retire.valid) begin
      tag_mem[retire.slot][wr_idx] <= retire.src_ip[ADDR_BITS-1:TAG_LSB];
      tgt_mem[retire.slot][wr_idx] <= retire.target_ip[ADDR_BITS-1:BLOCK_OFFSET_BITS];
    end
  end

endmodule

//--- src/fetch_top.sv
`timescale 1ns/1ns
//******************************
// fetch front end, one block per cycle
// retire strobes are always accepted, at most one per cycle
//******************************
module fetch_top
  import fetch_types_pkg::*;
  import retire_pkg::*;
#(
  parameter int PHT_INDEX_BITS = 10,
  parameter int TB_INDEX_BITS  = 9
) (
  input  logic         clk,
  input  logic         rst,
  input  addr_t        reset_ip,   // sampled while rst is high
  input  retire_t      retire,
  output fetch_state_t fetch,
  output logic         tag_fault
);

  addr_t      ip;
  ghist_t     ghist;
  slot_bits_t taken;
  addr_t      target0;
  addr_t      target1;
  slot_bits_t tag_hit;

  fetch_pc_gen #(
    .TB_INDEX_BITS(TB_INDEX_BITS)
  ) u_pc_gen (
    .clk      (clk),
    .rst      (rst),
    .reset_ip (reset_ip),
    .retire   (retire),
    .taken    (taken),
    .target0  (target0),
    .target1  (target1),
    .tag_hit  (tag_hit),
    .ip       (ip),
    .ghist    (ghist),
    .tag_fault(tag_fault)
  );

  direction_predictor #(
    .PHT_INDEX_BITS(PHT_INDEX_BITS)
  ) u_pred (
    .clk   (clk),
    .rst   (rst),
    .ip    (ip),
    .ghist (ghist),
    .retire(retire),
    .taken (taken)
  );

  target_buffer #(
    .TB_INDEX_BITS(TB_INDEX_BITS)
  ) u_tbuf (
    .clk    (clk),
    .rst    (rst),
    .ip     (ip),
    .retire (retire),
    .target0(target0),
    .target1(target1),
    .tag_hit(tag_hit)
  );

  assign fetch.ip    = ip;
  assign fetch.ghist = ghist;
  assign fetch.taken = taken;   // for the block now at ip

endmodule

//--- tb/fetch_assertions.sv
`timescale 1ns/1ns
//******************************
// bound into fetch_pc_gen, checks alignment, sticky fault and reset history
//******************************
module fetch_assertions
  import fetch_types_pkg::*;
(
  input logic   clk,
  input logic   rst,
  input addr_t  ip,
  input ghist_t ghist,
  input logic   tag_fault
);

  // every fetch address is a block address
  ip_aligned: assert property (@(posedge clk) disable iff (rst)
    ip[BLOCK_OFFSET_BITS-1:0] == '0)
    else $error("ip has low offset bits set");

  fault_sticky: assert property (@(posedge clk) disable iff (rst)
    !$fell(tag_fault))
    else $error("tag_fault fell without reset");

  // first edge with rst low still sees the reset history
  ghist_reset: assert property (@(posedge clk)
    $fell(rst) |-> ghist == '0)
    else $error("ghist not zero in the first cycle after reset");

endmodule

bind fetch_pc_gen fetch_assertions u_fetch_assertions (
  .clk      (clk),
  .rst      (rst),
  .ip       (ip),
  .ghist    (ghist),
  .tag_fault(tag_fault)
);

//--- tb/tb_top.sv
`timescale 1ns/1ns
//******************************
// directed tests for fetch_top with default parameters
// each test starts from its own reset
// inputs change on the falling edge
//******************************
module tb_top
  import fetch_types_pkg::*;
  import retire_pkg::*;
;

  localparam int TB_INDEX_BITS  = 9;      // fetch_top default
  localparam int TIMEOUT_CYCLES = 2000;

  logic         clk;
  logic         rst;
  addr_t        reset_ip;
  retire_t      retire;
  fetch_state_t fetch;
  logic         tag_fault;

  int errors;
  int checks;
  int cycle_count;

  fetch_top u_dut (
    .clk      (clk),
    .rst      (rst),
    .reset_ip (reset_ip),
    .retire   (retire),
    .fetch    (fetch),
    .tag_fault(tag_fault)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the tests did not finish", cycle_count);
    $display("Test failed");
    $finish;
  end

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_ghist(input string name, input ghist_t exp, input ghist_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_slots(input string name, input slot_bits_t exp,
                             input slot_bits_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // shifts in 1 for slot 0 taken, 01 for slot 1 and 00 for none
  function automatic ghist_t shift_hist(input ghist_t h, input slot_bits_t t);
    if (t[0]) begin
      return {h[14:0], 1'b1};
    end else if (t[1]) begin
      return {h[13:0], 2'b01};
    end
    return {h[13:0], 2'b00};
  endfunction

  function automatic addr_t block_addr(input addr_t base, input int unsigned n);
    return (base & ~addr_t'(BLOCK_BYTES - 1)) + addr_t'(BLOCK_BYTES) * addr_t'(n);
  endfunction

  function automatic addr_t pick_addr();
    addr_t a;
    a = {$urandom(), $urandom()};
    return a;
  endfunction

  // leaves time at a falling edge with rst just released
  task automatic apply_reset(input addr_t r);
    @(negedge clk);
    rst      = 1'b1;
    reset_ip = r;
    retire   = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
  endtask

  // drives a one cycle strobe and returns at the next falling edge
  task automatic retire_mispredict(input logic slot, input addr_t src, input addr_t tgt,
                                   input ghist_t h);
    retire.valid      = 1'b1;
    retire.slot       = slot;
    retire.mispredict = 1'b1;
    retire.src_ip     = src;
    retire.target_ip  = tgt;
    retire.ghist      = h;
    @(negedge clk);
    retire = '0;
  endtask

  task automatic wait_for_ip(input addr_t target, input int max_cycles);
    int n;
    n = 0;
    while (fetch.ip !== target && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (fetch.ip !== target) begin
      errors++;
      $display("fetch did not reach block %h within %0d cycles", target, max_cycles);
    end
  endtask

  task automatic test_sequential();
    addr_t base;
    addr_t exp_ip;
    base = pick_addr();
    apply_reset(base);
    exp_ip = block_addr(base, 0);
    check_addr("fetch.ip", exp_ip, fetch.ip);
    check_ghist("fetch.ghist", '0, fetch.ghist);
    check_slots("fetch.taken", 2'b00, fetch.taken);
    check_bit("tag_fault", 1'b0, tag_fault);
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      exp_ip = exp_ip + addr_t'(BLOCK_BYTES);
      check_addr("fetch.ip", exp_ip, fetch.ip);
      check_ghist("fetch.ghist", '0, fetch.ghist);
      check_slots("fetch.taken", 2'b00, fetch.taken);
    end
  endtask

  // a trained slot redirects fetch at X
  task automatic test_slot_redirect(input logic slot);
    addr_t      base;
    addr_t      x;
    addr_t      tgt;
    slot_bits_t exp_taken;
    base = pick_addr();
    tgt  = pick_addr();
    apply_reset(base);
    x = block_addr(base, 20);
    exp_taken = slot ? 2'b10 : 2'b01;
    retire_mispredict(slot, x, tgt, '0);
    wait_for_ip(x, 40);
    check_slots("fetch.taken", exp_taken, fetch.taken);
    check_ghist("fetch.ghist", '0, fetch.ghist);
    @(negedge clk);
    check_addr("fetch.ip", block_addr(tgt, 0), fetch.ip);
    check_ghist("fetch.ghist", shift_hist('0, exp_taken), fetch.ghist);
    check_bit("tag_fault", 1'b0, tag_fault);
  endtask

  task automatic test_untrain();
    addr_t base;
    addr_t x;
    addr_t tgt;
    base = pick_addr();
    tgt  = pick_addr();
    apply_reset(base);
    x = block_addr(base, 20);
    retire_mispredict(1'b0, x, tgt, '0);   // table A
    retire_mispredict(1'b0, x, tgt, '0);   // table B cancels it
    wait_for_ip(x, 40);
    check_slots("fetch.taken", 2'b00, fetch.taken);
    @(negedge clk);
    check_addr("fetch.ip", x + addr_t'(BLOCK_BYTES), fetch.ip);
    check_ghist("fetch.ghist", '0, fetch.ghist);
  endtask

  // W jumps to Y which shares the indices of X but not its tag
  task automatic test_tag_fault();
    addr_t base;
    addr_t w;
    addr_t x;
    addr_t y;
    addr_t tgt;
    base = pick_addr();
    tgt  = pick_addr();
    apply_reset(base);
    w = block_addr(base, 10);
    x = block_addr(base, 20);
    y = x + (addr_t'(1) << (BLOCK_OFFSET_BITS + TB_INDEX_BITS));
    retire_mispredict(1'b0, x, tgt, '0);
    retire_mispredict(1'b0, w, y, '0);
    wait_for_ip(w, 20);
    check_slots("fetch.taken", 2'b01, fetch.taken);
    // slot 1 flip lands in table C away from Y's entry
    retire_mispredict(1'b1, w, tgt, '0);
    check_addr("fetch.ip", y, fetch.ip);
    check_ghist("fetch.ghist", '0, fetch.ghist);
    check_slots("fetch.taken", 2'b01, fetch.taken);
    check_bit("tag_fault", 1'b0, tag_fault);
    @(negedge clk);
    check_addr("fetch.ip", block_addr(tgt, 0), fetch.ip);
    check_ghist("fetch.ghist", shift_hist('0, 2'b01), fetch.ghist);
    check_bit("tag_fault", 1'b1, tag_fault);
    repeat (4) begin
      @(negedge clk);
      check_bit("tag_fault", 1'b1, tag_fault);
    end
  endtask

  task automatic test_history_restore();
    addr_t       base;
    addr_t       exp_ip;
    ghist_t      g;
    int unsigned delay;
    for (int i = 0; i < 3; i++) begin
      base = pick_addr();
      apply_reset(base);
      delay = 1 + ($urandom() % 6);
      repeat (delay) @(negedge clk);
      exp_ip = block_addr(base, delay);
      g = ghist_t'($urandom());
      // src far from the fetch path so nothing aliases
      retire_mispredict(1'b0, exp_ip + addr_t'(BLOCK_BYTES * 128), pick_addr(), g);
      check_addr("fetch.ip", exp_ip + addr_t'(BLOCK_BYTES), fetch.ip);
      check_ghist("fetch.ghist", g, fetch.ghist);
      check_slots("fetch.taken", 2'b00, fetch.taken);
      @(negedge clk);
      check_addr("fetch.ip", exp_ip + addr_t'(2 * BLOCK_BYTES), fetch.ip);
      check_ghist("fetch.ghist", shift_hist(g, 2'b00), fetch.ghist);
    end
  endtask

  initial begin
    rst      = 1'b1;
    reset_ip = '0;
    retire   = '0;
    errors   = 0;
    checks   = 0;
    void'($urandom(32'ha987610e));

    test_sequential();
    test_slot_redirect(1'b0);
    test_slot_redirect(1'b1);
    test_untrain();
    test_tag_fault();
    test_history_restore();

    @(negedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- tb.f
src/fetch_types_pkg.sv
src/retire_pkg.sv
src/fetch_pc_gen.sv
src/direction_predictor.sv
src/target_buffer.sv
src/fetch_top.sv
tb/fetch_assertions.sv
tb/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_top -f tb.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
